// File: run_sim.sh
#!/bin/sh
# build and run the VGA frame buffer testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_vga_top_apb \
    -f vlog.f \
    -o sim_tb

# the simulator exit status is not used, the log decides
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "NO ERRORS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: src/apb_fb_slave.sv
`timescale 1ns/1ps

module apb_fb_slave
    import vga_pkg::*;
#(
    parameter int h_active = 640,
    parameter int v_active = 480,
    localparam int depth  = h_active * v_active,
    localparam int idx_w  = $clog2(depth),
    localparam int word_w = idx_msb - idx_lsb + 1
) (
    input  logic                  pclk,
    input  logic                  reset,
    input  logic [apb_addr_w-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [apb_data_w-1:0] pwdata,
    input  logic [apb_strb_w-1:0] pstrb,
    output logic                  pready,
    output logic [apb_data_w-1:0] prdata,
    output logic                  pslverr,
    output logic [idx_w-1:0]      host_index,
    output logic                  host_we,
    output logic [apb_strb_w-1:0] host_strb,
    output logic [apb_data_w-1:0] host_wdata,
    input  logic [apb_data_w-1:0] host_rdata
);

    localparam logic [word_w-1:0] depth_lim = word_w'(depth);

    logic [word_w-1:0] word_index;
    logic              in_range;
    logic              setup;
    logic              access;
    logic              range_ok_q;
    logic              read_q;

    assign word_index = paddr[idx_msb:idx_lsb];
    assign in_range   = (word_index < depth_lim);

    assign setup  = psel & ~penable;
    assign access = psel & penable;

    // transfer decode taken at the setup edge
    // paddr and pwrite are held through the access phase
    always_ff @(posedge pclk or posedge reset) begin
        if (reset) begin
            range_ok_q <= 1'b0;
            read_q     <= 1'b0;
        end else if (setup) begin
            range_ok_q <= in_range;
            read_q     <= ~pwrite;
        end
    end

    assign pready  = access;    // zero wait states
    assign pslverr = access & ~range_ok_q;

    // index already valid in setup so the buffer read lands in access
    assign host_index = word_index[idx_w-1:0];
    assign host_we    = access & ~read_q & range_ok_q;
    assign host_strb  = pstrb;
    assign host_wdata = pwdata;

    // zero on writes and on errors
    assign prdata = (access & read_q & range_ok_q) ? host_rdata : '0;

endmodule

// File: src/frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer
    import vga_pkg::*;
#(
    parameter int h_active = 640,
    parameter int v_active = 480,
    localparam int depth = h_active * v_active,
    localparam int idx_w = $clog2(depth)
) (
    input  logic                  pclk,
    input  logic [idx_w-1:0]      host_index,
    input  logic                  host_we,
    input  logic [apb_strb_w-1:0] host_strb,
    input  logic [apb_data_w-1:0] host_wdata,
    output logic [apb_data_w-1:0] host_rdata,
    input  logic [idx_w-1:0]      pix_index,
    output pixel_word_u           pix_data
);

    // one word per pixel
    pixel_word_u mem [depth];

    // host port, byte lane writes and a registered read
    always_ff @(posedge pclk) begin
        for (int i = 0; i < apb_strb_w; i++) begin
            if (host_we && host_strb[i]) begin
                mem[host_index].raw[lane_w*i +: lane_w] <= host_wdata[lane_w*i +: lane_w];
            end
        end
        host_rdata <= mem[host_index].raw;  // old data on a same-edge write
    end

    // video port reads every cycle, never stalls
    always_ff @(posedge pclk) begin
        pix_data <= mem[pix_index];
    end

endmodule

// File: src/vga_out.sv
`timescale 1ns/1ps

module vga_out
    import vga_pkg::*;
(
    input  logic        pclk,
    input  logic        reset,
    input  logic        scan_hsync,
    input  logic        scan_vsync,
    input  logic        scan_valid,
    input  pixel_word_u pix_data,
    output logic [7:0]  vga_r,
    output logic [7:0]  vga_g,
    output logic [7:0]  vga_b,
    output logic        vga_hsync,
    output logic        vga_vsync,
    output logic        vga_valid
);

    // first stage matches the buffer read latency
    logic hsync_d;
    logic vsync_d;
    logic valid_d;

    always_ff @(posedge pclk or posedge reset) begin
        if (reset) begin
            hsync_d <= 1'b1;
            vsync_d <= 1'b1;
            valid_d <= 1'b0;
        end else begin
            hsync_d <= scan_hsync;
            vsync_d <= scan_vsync;
            valid_d <= scan_valid;
        end
    end

    // pin register
    always_ff @(posedge pclk or posedge reset) begin
        if (reset) begin
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_valid <= 1'b0;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end else begin
            vga_hsync <= hsync_d;
            vga_vsync <= vsync_d;
            vga_valid <= valid_d;
            if (valid_d) begin
                vga_r <= pix_data.rgb.r;
                vga_g <= pix_data.rgb.g;
                vga_b <= pix_data.rgb.b;
            end else begin
                vga_r <= '0;    // blank outside active area
                vga_g <= '0;
                vga_b <= '0;
            end
        end
    end

endmodule

// File: src/vga_pkg.sv
package vga_pkg;

    localparam int apb_addr_w = 32;
    localparam int apb_data_w = 32;
    localparam int apb_strb_w = 4;
    localparam int lane_w     = apb_data_w / apb_strb_w;

    // word index field of paddr
    localparam int idx_lsb = 2;
    localparam int idx_msb = 21;

    // one frame buffer word, raw for APB, colour bytes for the video side
    typedef union packed {
        logic [apb_data_w-1:0] raw;
        struct packed {
            logic [7:0] pad;
            logic [7:0] r;
            logic [7:0] g;
            logic [7:0] b;
        } rgb;
    } pixel_word_u;

endpackage

// File: src/vga_scan.sv
`timescale 1ns/1ps

module vga_scan #(
    parameter int h_sync   = 96,
    parameter int h_back   = 48,
    parameter int h_active = 640,
    parameter int h_front  = 16,
    parameter int v_sync   = 2,
    parameter int v_back   = 33,
    parameter int v_active = 480,
    parameter int v_front  = 10,
    localparam int depth = h_active * v_active,
    localparam int idx_w = $clog2(depth)
) (
    input  logic             pclk,
    input  logic             reset,
    output logic [idx_w-1:0] pix_index,
    output logic             scan_hsync,
    output logic             scan_vsync,
    output logic             scan_valid
);

    localparam int h_total = h_sync + h_back + h_active + h_front;
    localparam int v_total = v_sync + v_back + v_active + v_front;
    localparam int xw      = $clog2(h_total);
    localparam int yw      = $clog2(v_total);

    localparam logic [xw-1:0] x_last   = xw'(h_total - 1);
    localparam logic [xw-1:0] x_sync   = xw'(h_sync);
    localparam logic [xw-1:0] x_act_lo = xw'(h_sync + h_back);
    localparam logic [xw-1:0] x_act_hi = xw'(h_sync + h_back + h_active);

    localparam logic [yw-1:0] y_last   = yw'(v_total - 1);
    localparam logic [yw-1:0] y_sync   = yw'(v_sync);
    localparam logic [yw-1:0] y_act_lo = yw'(v_sync + v_back);
    localparam logic [yw-1:0] y_act_hi = yw'(v_sync + v_back + v_active);

    logic [xw-1:0] x_cnt;
    logic [yw-1:0] y_cnt;
    logic          line_end;
    logic          frame_end;
    logic          h_valid;
    logic          v_valid;

    assign line_end  = (x_cnt == x_last);
    assign frame_end = line_end && (y_cnt == y_last);

    // count 0 is the first clock of the sync pulse
    always_ff @(posedge pclk or posedge reset) begin
        if (reset) begin
            x_cnt <= '0;
        end else if (line_end) begin
            x_cnt <= '0;
        end else begin
            x_cnt <= x_cnt + 1'b1;
        end
    end

    always_ff @(posedge pclk or posedge reset) begin
        if (reset) begin
            y_cnt <= '0;
        end else if (frame_end) begin
            y_cnt <= '0;
        end else if (line_end) begin
            y_cnt <= y_cnt + 1'b1;
        end
    end

    assign scan_hsync = (x_cnt >= x_sync);  // low for the first h_sync counts
    assign scan_vsync = (y_cnt >= y_sync);

    assign h_valid    = (x_cnt >= x_act_lo) && (x_cnt < x_act_hi);
    assign v_valid    = (y_cnt >= y_act_lo) && (y_cnt < y_act_hi);
    assign scan_valid = h_valid && v_valid;

    // raster index of the current active position
    // steps once per visible pixel instead of x + y*width
    always_ff @(posedge pclk or posedge reset) begin
        if (reset) begin
            pix_index <= '0;
        end else if (frame_end) begin
            pix_index <= '0;
        end else if (scan_valid) begin
            pix_index <= pix_index + 1'b1;
        end
    end

endmodule

// File: src/vga_top_apb.sv
`timescale 1ns/1ps

module vga_top_apb
    import vga_pkg::*;
#(
    parameter int h_sync   = 96,
    parameter int h_back   = 48,
    parameter int h_active = 640,
    parameter int h_front  = 16,
    parameter int v_sync   = 2,
    parameter int v_back   = 33,
    parameter int v_active = 480,
    parameter int v_front  = 10,
    localparam int fb_depth = h_active * v_active,
    localparam int idx_w    = $clog2(fb_depth)
) (
    input  logic                  pclk,
    input  logic                  reset,
    input  logic [apb_addr_w-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic [2:0]            pprot,    // no protection checks
    input  logic                  pwrite,
    input  logic [apb_data_w-1:0] pwdata,
    input  logic [apb_strb_w-1:0] pstrb,
    output logic                  pready,
    output logic [apb_data_w-1:0] prdata,
    output logic                  pslverr,
    output logic [7:0]            vga_r,
    output logic [7:0]            vga_g,
    output logic [7:0]            vga_b,
    output logic                  vga_hsync,
    output logic                  vga_vsync,
    output logic                  vga_valid
);

    logic [idx_w-1:0]      host_index;
    logic                  host_we;
    logic [apb_strb_w-1:0] host_strb;
    logic [apb_data_w-1:0] host_wdata;
    logic [apb_data_w-1:0] host_rdata;
    logic [idx_w-1:0]      pix_index;
    pixel_word_u           pix_data;
    logic                  scan_hsync;
    logic                  scan_vsync;
    logic                  scan_valid;

    apb_fb_slave #(
        .h_active (h_active),
        .v_active (v_active)
    ) u_apb_fb_slave (
        .pclk       (pclk),
        .reset      (reset),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .pstrb      (pstrb),
        .pready     (pready),
        .prdata     (prdata),
        .pslverr    (pslverr),
        .host_index (host_index),
        .host_we    (host_we),
        .host_strb  (host_strb),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata)
    );

    frame_buffer #(
        .h_active (h_active),
        .v_active (v_active)
    ) u_frame_buffer (
        .pclk       (pclk),
        .host_index (host_index),
        .host_we    (host_we),
        .host_strb  (host_strb),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata),
        .pix_index  (pix_index),
        .pix_data   (pix_data)
    );

    vga_scan #(
        .h_sync   (h_sync),
        .h_back   (h_back),
        .h_active (h_active),
        .h_front  (h_front),
        .v_sync   (v_sync),
        .v_back   (v_back),
        .v_active (v_active),
        .v_front  (v_front)
    ) u_vga_scan (
        .pclk       (pclk),
        .reset      (reset),
        .pix_index  (pix_index),
        .scan_hsync (scan_hsync),
        .scan_vsync (scan_vsync),
        .scan_valid (scan_valid)
    );

    vga_out u_vga_out (
        .pclk       (pclk),
        .reset      (reset),
        .scan_hsync (scan_hsync),
        .scan_vsync (scan_vsync),
        .scan_valid (scan_valid),
        .pix_data   (pix_data),
        .vga_r      (vga_r),
        .vga_g      (vga_g),
        .vga_b      (vga_b),
        .vga_hsync  (vga_hsync),
        .vga_vsync  (vga_vsync),
        .vga_valid  (vga_valid)
    );

endmodule

// File: tb/tb_vga_top_apb.sv
`timescale 1ns/1ps

module tb_vga_top_apb;

    localparam int h_sync   = 4;
    localparam int h_back   = 3;
    localparam int h_active = 16;
    localparam int h_front  = 2;
    localparam int v_sync   = 2;
    localparam int v_back   = 2;
    localparam int v_active = 8;
    localparam int v_front  = 1;
    localparam int h_total  = h_sync + h_back + h_active + h_front;
    localparam int v_total  = v_sync + v_back + v_active + v_front;
    localparam int fb_depth = h_active * v_active;
    localparam int frame_clocks = h_total * v_total;
    localparam int n_rows = 14;
    localparam int timeout_cycles = 16 + 2 * n_rows + 2 * fb_depth + 3 * frame_clocks + 100;

    // write, address, write data, strobe, expected read data, expected error
    localparam logic [101:0] xfer_table [n_rows] = '{
        {1'b1, 32'h0000_0000, 32'h1122_3344, 4'b1111, 32'h0000_0000, 1'b0},
        {1'b1, 32'h0000_0000, 32'haabb_ccdd, 4'b0101, 32'h0000_0000, 1'b0},
        {1'b1, 32'h0000_0004, 32'h0102_0304, 4'b1111, 32'h0000_0000, 1'b0},
        {1'b1, 32'h0000_0004, 32'hffee_ddcc, 4'b1010, 32'h0000_0000, 1'b0},
        {1'b1, 32'h0000_01fc, 32'hcafe_f00d, 4'b1111, 32'h0000_0000, 1'b0},
        {1'b1, 32'h0000_01fc, 32'h0000_0000, 4'b0010, 32'h0000_0000, 1'b0},
        {1'b0, 32'h0000_0000, 32'h0000_0000, 4'b0000, 32'h11bb_33dd, 1'b0},
        {1'b0, 32'h0000_0004, 32'h0000_0000, 4'b0000, 32'hff02_dd04, 1'b0},
        {1'b0, 32'h0000_01fc, 32'h0000_0000, 4'b0000, 32'hcafe_000d, 1'b0},
        {1'b1, 32'h0000_0200, 32'hdead_beef, 4'b1111, 32'h0000_0000, 1'b1},  // index 128
        {1'b0, 32'h0000_0200, 32'h0000_0000, 4'b0000, 32'h0000_0000, 1'b1},
        {1'b1, 32'h003f_fffc, 32'h5a5a_5a5a, 4'b1111, 32'h0000_0000, 1'b1},
        {1'b0, 32'h0000_0000, 32'h0000_0000, 4'b0000, 32'h11bb_33dd, 1'b0},
        {1'b0, 32'h0000_01fc, 32'h0000_0000, 4'b0000, 32'hcafe_000d, 1'b0}
    };

    logic        pclk;
    logic        reset;
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic [2:0]  pprot;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [3:0]  pstrb;
    logic        pready;
    logic [31:0] prdata;
    logic        pslverr;
    logic [7:0]  vga_r;
    logic [7:0]  vga_g;
    logic [7:0]  vga_b;
    logic        vga_hsync;
    logic        vga_vsync;
    logic        vga_valid;

    logic [31:0] lfsr_state;
    logic [31:0] model [fb_depth];  // expected frame contents
    int          cycle_count = 0;

    vga_top_apb #(
        .h_sync   (h_sync),
        .h_back   (h_back),
        .h_active (h_active),
        .h_front  (h_front),
        .v_sync   (v_sync),
        .v_back   (v_back),
        .v_active (v_active),
        .v_front  (v_front)
    ) u_vga_top_apb (
        .pclk      (pclk),
        .reset     (reset),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pprot     (pprot),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .pstrb     (pstrb),
        .pready    (pready),
        .prdata    (prdata),
        .pslverr   (pslverr),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_valid (vga_valid)
    );

    initial begin
        pclk = 1'b0;
        forever #4 pclk = ~pclk;
    end

    always @(posedge pclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at time %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    // 32-bit Fibonacci with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_random_word(output logic [31:0] w);
        for (int b = 0; b < 32; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w[b] = lfsr_state[0];
        end
    endtask

    // setup then access phase with the result sampled mid access
    task automatic apb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [31:0] rdata,
                            output logic err, output logic rdy);
        @(posedge pclk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        pstrb   <= strb;
        @(posedge pclk);
        penable <= 1'b1;
        @(negedge pclk);
        rdata = prdata;
        err   = pslverr;
        rdy   = pready;
    endtask

    task automatic apb_idle();
        @(posedge pclk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic check_frames();
        int pix;
        int h_low;
        int valid_cnt;
        int valid_lines;
        int vsync_lines;
        logic prev_vsync;
        // falling vsync marks the pin cycle of position (0, 0)
        @(negedge pclk);
        prev_vsync = vga_vsync;
        @(negedge pclk);
        while (!(prev_vsync && !vga_vsync)) begin
            prev_vsync = vga_vsync;
            @(negedge pclk);
        end
        for (int f = 0; f < 2; f++) begin
            pix = 0;
            valid_lines = 0;
            vsync_lines = 0;
            for (int y = 0; y < v_total; y++) begin
                h_low = 0;
                valid_cnt = 0;
                if (!vga_vsync) begin
                    vsync_lines++;
                end
                for (int x = 0; x < h_total; x++) begin
                    if (!vga_hsync) begin
                        h_low++;
                    end
                    if (vga_valid) begin
                        valid_cnt++;
                        if (pix < fb_depth) begin
                            check_value("vga_r", 32'(vga_r), 32'(model[pix][23:16]));
                            check_value("vga_g", 32'(vga_g), 32'(model[pix][15:8]));
                            check_value("vga_b", 32'(vga_b), 32'(model[pix][7:0]));
                        end
                        pix++;
                    end
                    @(negedge pclk);
                end
                check_value("hsync low clocks", h_low, h_sync);
                if (valid_cnt != 0) begin
                    check_value("valid clocks per line", valid_cnt, h_active);
                    valid_lines++;
                end
            end
            check_value("vsync low lines", vsync_lines, v_sync);
            check_value("valid lines", valid_lines, v_active);
        end
    endtask

    initial begin
        logic [101:0] row;
        logic [31:0]  w;
        logic [31:0]  rd;
        logic         err;
        logic         rdy;
        reset      = 1'b1;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pprot      = 3'b010;
        pwrite     = 1'b0;
        pwdata     = '0;
        pstrb      = '0;
        lfsr_state = 32'h9eac;

        repeat (16) @(posedge pclk);
        reset <= 1'b0;
        @(negedge pclk);
        check_value("vga_hsync", 32'(vga_hsync), 32'd1);
        check_value("vga_vsync", 32'(vga_vsync), 32'd1);
        check_value("vga_valid", 32'(vga_valid), 32'd0);
        check_value("vga_r", 32'(vga_r), 32'd0);
        check_value("vga_g", 32'(vga_g), 32'd0);
        check_value("vga_b", 32'(vga_b), 32'd0);
        check_value("pready", 32'(pready), 32'd0);
        check_value("pslverr", 32'(pslverr), 32'd0);
        repeat (2) @(negedge pclk);
        check_value("vga_hsync", 32'(vga_hsync), 32'd0);  // line 0 sync start
        check_value("vga_vsync", 32'(vga_vsync), 32'd0);

        for (int i = 0; i < n_rows; i++) begin
            row = xfer_table[i];
            apb_xfer(row[101], row[100:69], row[68:37], row[36:33], rd, err, rdy);
            check_value("pready", 32'(rdy), 32'd1);
            check_value("prdata", rd, row[32:1]);
            check_value("pslverr", 32'(err), 32'(row[0]));
        end

        for (int i = 0; i < fb_depth; i++) begin
            take_random_word(w);
            model[i] = w;
            apb_xfer(1'b1, i * 4, w, 4'b1111, rd, err, rdy);
            check_value("pready", 32'(rdy), 32'd1);
            check_value("pslverr", 32'(err), 32'd0);
        end
        apb_idle();

        check_frames();
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: tb/vga_properties.sv
`timescale 1ns/1ps

module vga_properties (
    input logic       pclk,
    input logic       reset,
    input logic       psel,
    input logic       penable,
    input logic       pready,
    input logic       pslverr,
    input logic       vga_hsync,
    input logic       vga_vsync,
    input logic       vga_valid,
    input logic [7:0] vga_r,
    input logic [7:0] vga_g,
    input logic [7:0] vga_b
);

    // zero wait states
    a_ready_access: assert property (@(posedge pclk) disable iff (reset)
        pready == (psel && penable))
        else $error("pready differs from psel and penable");

    a_err_ready: assert property (@(posedge pclk) disable iff (reset)
        pslverr |-> pready)
        else $error("pslverr raised outside a completing access phase");

    a_valid_sync: assert property (@(posedge pclk) disable iff (reset)
        vga_valid |-> (vga_hsync && vga_vsync))
        else $error("vga_valid high during a sync pulse");

    a_blank: assert property (@(posedge pclk) disable iff (reset)
        !vga_valid |-> (vga_r == 8'd0 && vga_g == 8'd0 && vga_b == 8'd0))
        else $error("colour not blanked while vga_valid is low");

endmodule

bind vga_top_apb vga_properties u_vga_properties (
    .pclk      (pclk),
    .reset     (reset),
    .psel      (psel),
    .penable   (penable),
    .pready    (pready),
    .pslverr   (pslverr),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync),
    .vga_valid (vga_valid),
    .vga_r     (vga_r),
    .vga_g     (vga_g),
    .vga_b     (vga_b)
);

// File: vlog.f
src/vga_pkg.sv
src/apb_fb_slave.sv
src/frame_buffer.sv
src/vga_scan.sv
src/vga_out.sv
src/vga_top_apb.sv
tb/vga_properties.sv
tb/tb_vga_top_apb.sv
